// ==== ahb_subsys_top.f ====
ahb_subsys_pkg.sv
ahb_decoder.sv
ahb_sram_slave.sv
ahb_timer_slave.sv
ahb_subsys_top.sv
tb_ahb_checker.sv
tb_ahb_subsys.sv

// ==== Bender.yml ====
package:
  name: ahb_subsys

sources:
  - ahb_subsys_pkg.sv
  - ahb_decoder.sv
  - ahb_sram_slave.sv
  - ahb_timer_slave.sv
  - ahb_subsys_top.sv
  - target: test
    files:
      - tb_ahb_checker.sv
      - tb_ahb_subsys.sv

// ==== tb_ahb_subsys.sv ====
////////////////////////////////////////
// Testbench top with clock, reset,
// stimulus table and AHB driver
////////////////////////////////////////

`timescale 1ns/1ps

module tb_ahb_subsys;

   import ahb_subsys_pkg::*;

   localparam logic [1:0] OP_WR    = 2'd0;
   localparam logic [1:0] OP_RD    = 2'd1;
   localparam logic [1:0] OP_WAIT  = 2'd2;
   // Irq expectation codes with bit 1 as compare enable
   localparam logic [1:0] IRQ_ANY  = 2'b00;
   localparam logic [1:0] IRQ_LOW  = 2'b10;
   localparam logic [1:0] IRQ_HIGH = 2'b11;
   localparam int MAX_ROWS  = 64;
   localparam int MAX_POLLS = 64;

   typedef struct packed {
      logic [1:0] op;
      haddr_t     addr;
      hsize_t     size;
      hdata_t     wdata;
      hdata_t     exp_rdata;
      logic       exp_resp;
      logic [1:0] exp_irq;
   } row_t;

   // DUT ports
   logic    hclk;
   logic    arst_n;
   logic    hwrite;
   haddr_t  haddr;
   hsize_t  hsize;
   htrans_t htrans;
   hdata_t  hwdata;
   hdata_t  hrdata;
   logic    hready;
   logic    hresp;
   logic    irq;

   // Expected values handed to the checker with each address phase
   logic       exp_read;
   hdata_t     exp_rdata;
   logic       exp_resp;
   logic [1:0] exp_irq;
   int         checks;
   int         errors;

   // Stimulus table and SRAM shadow
   row_t        rows [MAX_ROWS];
   int          n_rows;
   hdata_t      shadow [SRAM_DEPTH];
   haddr_t      rnd_addr [6];
   int unsigned lcg_state = 82;

   int n_issued;
   int other_errors;
   int cycle_cnt;
   int timeout_limit;

   ahb_subsys_top u_ahb_subsys_top (
      .hclk_i   ( hclk   ),
      .arst_n_i ( arst_n ),
      .hwrite_i ( hwrite ),
      .haddr_i  ( haddr  ),
      .hsize_i  ( hsize  ),
      .htrans_i ( htrans ),
      .hwdata_i ( hwdata ),
      .hrdata_o ( hrdata ),
      .hready_o ( hready ),
      .hresp_o  ( hresp  ),
      .irq_o    ( irq    )
   );

   tb_ahb_checker u_checker (
      .hclk_i      ( hclk      ),
      .arst_n_i    ( arst_n    ),
      .htrans_i    ( htrans    ),
      .hready_i    ( hready    ),
      .hresp_i     ( hresp     ),
      .hrdata_i    ( hrdata    ),
      .irq_i       ( irq       ),
      .exp_read_i  ( exp_read  ),
      .exp_rdata_i ( exp_rdata ),
      .exp_resp_i  ( exp_resp  ),
      .exp_irq_i   ( exp_irq   ),
      .checks_o    ( checks    ),
      .errors_o    ( errors    )
   );

   // 4 ns clock
   always #2 hclk = ~hclk;

   ////////////////////////////////////////
   // Table building
   ////////////////////////////////////////

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic add_row(input logic [1:0] op, input haddr_t addr, input hsize_t size,
                          input hdata_t wdata, input hdata_t exp_rd, input logic resp,
                          input logic [1:0] irq_exp);
      rows[n_rows] = {op, addr, size, wdata, exp_rd, resp, irq_exp};
      n_rows++;
   endtask

   // Random data write that updates the shadow on the addressed bytes only
   task automatic sram_wr(input haddr_t addr, input hsize_t size);
      hdata_t data;
      int     nbytes;
      int     first;
      data = lcg_next();
      // Naturally aligned block of 1, 2 or 4 bytes holding the address
      nbytes = 1 << size;
      first  = addr[1:0] & ~(nbytes - 1);
      for (int b = 0; b < 4; b++) begin
         if (b >= first && b < first + nbytes) begin
            shadow[addr[10:2]][8*b +: 8] = data[8*b +: 8];
         end
      end
      add_row(OP_WR, addr, size, data, '0, 1'b0, IRQ_LOW);
   endtask

   task automatic sram_rd(input haddr_t addr);
      add_row(OP_RD, addr, HSIZE_WORD, '0, shadow[addr[10:2]], 1'b0, IRQ_LOW);
   endtask

   task automatic build_table();
      int k;
      n_rows = 0;
      // Word writes to random words and their read back
      for (k = 0; k < 6; k++) begin
         rnd_addr[k] = haddr_t'(((lcg_next() >> 16) % SRAM_DEPTH) * 4);
         sram_wr(rnd_addr[k], HSIZE_WORD);
      end
      for (k = 0; k < 6; k++) begin
         sram_rd(rnd_addr[k]);
      end
      // Byte and halfword merge into word 100
      sram_wr(32'h190, HSIZE_WORD);
      sram_wr(32'h191, HSIZE_BYTE);
      sram_wr(32'h192, HSIZE_HALF);
      sram_rd(32'h190);
      // Reads right behind writes for full and partial forwarding
      sram_wr(32'h3FC, HSIZE_WORD);
      sram_rd(32'h3FC);
      sram_wr(32'h3FE, HSIZE_HALF);
      sram_rd(32'h3FC);
      // Timer setup, pending flag, clear and stop
      add_row(OP_WR, TIMER_BASE + TIMER_CMP_OFS, HSIZE_WORD, 32'd20, '0, 1'b0, IRQ_LOW);
      add_row(OP_WR, TIMER_BASE + TIMER_CTRL_OFS, HSIZE_WORD, 32'd3, '0, 1'b0, IRQ_LOW);
      add_row(OP_RD, TIMER_BASE + TIMER_CMP_OFS, HSIZE_WORD, '0, 32'd20, 1'b0, IRQ_LOW);
      add_row(OP_RD, TIMER_BASE + TIMER_CTRL_OFS, HSIZE_WORD, '0, 32'd3, 1'b0, IRQ_LOW);
      add_row(OP_WAIT, TIMER_BASE + TIMER_STAT_OFS, HSIZE_WORD, '0, '0, 1'b0, IRQ_ANY);
      add_row(OP_WR, TIMER_BASE + TIMER_STAT_OFS, HSIZE_WORD, 32'd1, '0, 1'b0, IRQ_HIGH);
      add_row(OP_RD, TIMER_BASE + TIMER_STAT_OFS, HSIZE_WORD, '0, 32'd0, 1'b0, IRQ_LOW);
      add_row(OP_WR, TIMER_BASE + TIMER_CTRL_OFS, HSIZE_WORD, 32'd0, '0, 1'b0, IRQ_LOW);
      add_row(OP_RD, TIMER_BASE + TIMER_CTRL_OFS, HSIZE_WORD, '0, 32'd0, 1'b0, IRQ_LOW);
      // Unmapped read and write followed by an SRAM read
      add_row(OP_RD, 32'h6000_0000, HSIZE_WORD, '0, '0, 1'b1, IRQ_LOW);
      add_row(OP_WR, 32'h6000_0004, HSIZE_WORD, lcg_next(), '0, 1'b1, IRQ_LOW);
      sram_rd(rnd_addr[0]);
   endtask

   ////////////////////////////////////////
   // Bus driver
   ////////////////////////////////////////

   // Drives an address phase and returns on the accepting edge with hwdata set
   task automatic issue(input row_t r);
      haddr     <= r.addr;
      hwrite    <= (r.op == OP_WR);
      hsize     <= r.size;
      htrans    <= HTRANS_NONSEQ;
      exp_read  <= (r.op == OP_RD);
      exp_rdata <= r.exp_rdata;
      exp_resp  <= r.exp_resp;
      exp_irq   <= r.exp_irq;
      do @(negedge hclk); while (!hready);
      @(posedge hclk);
      hwdata <= r.wdata;
      n_issued++;
   endtask

   // Idle bus until the last data phase ends
   task automatic finish_data_phase(output hdata_t rdata);
      htrans <= HTRANS_IDLE;
      do @(negedge hclk); while (!hready);
      rdata = hrdata;
      @(posedge hclk);
   endtask

   task automatic poll_stat(input haddr_t addr);
      row_t   r;
      hdata_t rd;
      int     polls;
      r = '0;
      r.op = OP_WAIT;
      r.addr = addr;
      r.size = HSIZE_WORD;
      r.exp_irq = IRQ_ANY;
      rd = '0;
      polls = 0;
      while (!rd[0] && polls < MAX_POLLS) begin
         issue(r);
         finish_data_phase(rd);
         polls++;
      end
      if (!rd[0]) begin
         $display("Timer pending bit still clear after %0d polls of STAT", polls);
         other_errors++;
      end
   endtask

   // Run limit from the table length
   always @(posedge hclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_limit) begin
         $display("Timeout, run stopped after %0d cycles", cycle_cnt);
         $display("Checked %0d transfers, %0d check errors, %0d other errors",
                  checks, errors, other_errors + 1);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      hdata_t last;
      hclk         = 1'b0;
      arst_n       = 1'b0;
      hwrite       = 1'b0;
      haddr        = '0;
      hsize        = HSIZE_WORD;
      htrans       = HTRANS_IDLE;
      hwdata       = '0;
      exp_read     = 1'b0;
      exp_rdata    = '0;
      exp_resp     = 1'b0;
      exp_irq      = IRQ_ANY;
      n_issued     = 0;
      other_errors = 0;
      cycle_cnt    = 0;
      build_table();
      timeout_limit = n_rows * 70 + 200;
      repeat (5) @(posedge hclk);
      arst_n <= 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         if (rows[i].op == OP_WAIT) begin
            poll_stat(rows[i].addr);
         end else begin
            issue(rows[i]);
         end
      end
      finish_data_phase(last);
      repeat (2) @(posedge hclk);
      if (checks != n_issued) begin
         $display("Transfer count mismatch, %0d issued and %0d completed", n_issued, checks);
         other_errors++;
      end
      $display("Checked %0d transfers, %0d check errors, %0d other errors",
               checks, errors, other_errors);
      if (errors == 0 && other_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== tb_ahb_checker.sv ====
////////////////////////////////////////
// Testbench checker for data phases,
// responses, irq and reset values
////////////////////////////////////////

`timescale 1ns/1ps

module tb_ahb_checker (
   input  logic                    hclk_i,
   input  logic                    arst_n_i,
   input  ahb_subsys_pkg::htrans_t htrans_i,
   input  logic                    hready_i,
   input  logic                    hresp_i,
   input  ahb_subsys_pkg::hdata_t  hrdata_i,
   input  logic                    irq_i,
   input  logic                    exp_read_i,
   input  ahb_subsys_pkg::hdata_t  exp_rdata_i,
   input  logic                    exp_resp_i,
   // Bit 1 enables the irq compare, bit 0 is the level
   input  logic [1:0]              exp_irq_i,
   output int                      checks_o,
   output int                      errors_o
);

   import ahb_subsys_pkg::*;

   // Expected values of the data phase in flight
   logic       dp_valid;
   logic       dp_read;
   hdata_t     dp_rdata;
   logic       dp_resp;
   logic [1:0] dp_irq;
   // First ERROR cycle seen for this transfer
   logic       saw_wait;

   initial begin
      dp_valid = 1'b0;
      saw_wait = 1'b0;
      checks_o = 0;
      errors_o = 0;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         errors_o++;
      end
   endtask

   ////////////////////////////////////////
   // Mid-cycle sampling, outputs stable
   ////////////////////////////////////////

   always @(negedge hclk_i) begin
      if (!arst_n_i) begin
         dp_valid = 1'b0;
         saw_wait = 1'b0;
         // Idle bus values while in reset
         compare_value("hready_o", hready_i, 1'b1);
         compare_value("hresp_o", hresp_i, 1'b0);
         compare_value("irq_o", irq_i, 1'b0);
         compare_value("hrdata_o", hrdata_i, '0);
      end else begin
         if (dp_valid) begin
            if (!hready_i) begin
               // Only legal stall is the first ERROR cycle
               if (hresp_i !== 1'b1 || !dp_resp) begin
                  $display("Unexpected wait state at %0t ns", $time);
                  errors_o++;
               end
               saw_wait = 1'b1;
            end else begin
               checks_o++;
               compare_value("hresp_o", hresp_i, dp_resp);
               if (dp_resp && !saw_wait) begin
                  $display("ERROR response without its first cycle at %0t ns", $time);
                  errors_o++;
               end
               if (dp_read) begin
                  compare_value("hrdata_o", hrdata_i, dp_rdata);
               end
               if (dp_irq[1]) begin
                  compare_value("irq_o", irq_i, dp_irq[0]);
               end
               dp_valid = 1'b0;
               saw_wait = 1'b0;
            end
         end
         // Address phase taken on the coming edge
         if (hready_i && (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ)) begin
            dp_valid = 1'b1;
            dp_read  = exp_read_i;
            dp_rdata = exp_rdata_i;
            dp_resp  = exp_resp_i;
            dp_irq   = exp_irq_i;
         end
      end
   end

endmodule

// ==== ahb_subsys_top.sv ====
////////////////////////////////////////
// AHB-lite subsystem with decoder,
// SRAM slave and timer slave
////////////////////////////////////////

`timescale 1ns/1ps

module ahb_subsys_top (
   input  logic                    hclk_i,
   input  logic                    arst_n_i,
   input  logic                    hwrite_i,
   input  ahb_subsys_pkg::haddr_t  haddr_i,
   input  ahb_subsys_pkg::hsize_t  hsize_i,
   input  ahb_subsys_pkg::htrans_t htrans_i,
   input  ahb_subsys_pkg::hdata_t  hwdata_i,
   output ahb_subsys_pkg::hdata_t  hrdata_o,
   output logic                    hready_o,
   output logic                    hresp_o,
   output logic                    irq_o
);

   import ahb_subsys_pkg::*;

   ////////////////////////////////////////
   // Slave side wires
   ////////////////////////////////////////

   // One-cycle selects from the decoder
   logic   sel_sram;
   logic   sel_timer;

   // Data-phase read data per slave
   hdata_t sram_rdata;
   hdata_t timer_rdata;

   ////////////////////////////////////////
   // Instances
   ////////////////////////////////////////

   // Address decode, response mux and ERROR handling
   ahb_decoder u_decoder (
      .hclk_i        ( hclk_i      ),
      .arst_n_i      ( arst_n_i    ),
      .haddr_i       ( haddr_i     ),
      .htrans_i      ( htrans_i    ),
      .sram_rdata_i  ( sram_rdata  ),
      .timer_rdata_i ( timer_rdata ),
      .sel_sram_o    ( sel_sram    ),
      .sel_timer_o   ( sel_timer   ),
      .hrdata_o      ( hrdata_o    ),
      .hready_o      ( hready_o    ),
      .hresp_o       ( hresp_o     )
   );

   // Slave 0
   ahb_sram_slave u_sram (
      .hclk_i   ( hclk_i     ),
      .arst_n_i ( arst_n_i   ),
      .sel_i    ( sel_sram   ),
      .hwrite_i ( hwrite_i   ),
      .haddr_i  ( haddr_i    ),
      .hsize_i  ( hsize_i    ),
      .hwdata_i ( hwdata_i   ),
      .hrdata_o ( sram_rdata )
   );

   // Slave 1, word access only
   ahb_timer_slave u_timer (
      .hclk_i   ( hclk_i      ),
      .arst_n_i ( arst_n_i    ),
      .sel_i    ( sel_timer   ),
      .hwrite_i ( hwrite_i    ),
      .haddr_i  ( haddr_i     ),
      .hwdata_i ( hwdata_i    ),
      .hrdata_o ( timer_rdata ),
      .irq_o    ( irq_o       )
   );

endmodule

// ==== ahb_timer_slave.sv ====
////////////////////////////////////////
// Compare-match timer slave with
// pending flag and interrupt
////////////////////////////////////////

`timescale 1ns/1ps

module ahb_timer_slave (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic                   sel_i,
   input  logic                   hwrite_i,
   input  ahb_subsys_pkg::haddr_t haddr_i,
   input  ahb_subsys_pkg::hdata_t hwdata_i,
   output ahb_subsys_pkg::hdata_t hrdata_o,
   output logic                   irq_o
);

   import ahb_subsys_pkg::*;

   // Data phase of the transfer in flight
   logic       dp_wr_q;
   logic [5:0] dp_ofs_q;

   // Register write strobes
   logic       wr_ctrl;
   logic       wr_cmp;
   logic       wr_cnt;
   logic       wr_stat;

   // Timer registers
   // ctrl_q[0] count enable, ctrl_q[1] irq enable
   logic [1:0] ctrl_q;
   hdata_t     cmp_q;
   hdata_t     cnt_q;
   logic       stat_q;

   // Counting and at compare value
   logic       match;

   ////////////////////////////////////////
   // Bus side
   ////////////////////////////////////////

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_wr_q <= 1'b0;
      end else begin
         dp_wr_q <= sel_i && hwrite_i;
      end
   end

   // Register offset inside the timer window
   always_ff @(posedge hclk_i) begin
      if (sel_i) begin
         dp_ofs_q <= haddr_i[5:0];
      end
   end

   // Word-wide writes decoded in the data phase
   assign wr_ctrl = dp_wr_q && (dp_ofs_q == TIMER_CTRL_OFS);
   assign wr_cmp  = dp_wr_q && (dp_ofs_q == TIMER_CMP_OFS);
   assign wr_cnt  = dp_wr_q && (dp_ofs_q == TIMER_CNT_OFS);
   assign wr_stat = dp_wr_q && (dp_ofs_q == TIMER_STAT_OFS);

   // Read mux, holes in the window read zero
   always_comb begin
      hrdata_o = '0;
      case (dp_ofs_q)
         TIMER_CTRL_OFS: hrdata_o[1:0] = ctrl_q;
         TIMER_CMP_OFS:  hrdata_o = cmp_q;
         TIMER_CNT_OFS:  hrdata_o = cnt_q;
         TIMER_STAT_OFS: hrdata_o[0] = stat_q;
         default:        hrdata_o = '0;
      endcase
   end

   ////////////////////////////////////////
   // Counter
   ////////////////////////////////////////

   assign match = ctrl_q[0] && (cnt_q == cmp_q);

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q <= 2'b00;
         cmp_q  <= '0;
      end else begin
         if (wr_ctrl) begin
            ctrl_q <= hwdata_i[1:0];
         end
         if (wr_cmp) begin
            cmp_q <= hwdata_i;
         end
      end
   end

   // Bus load beats the count step
   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (wr_cnt) begin
         cnt_q <= hwdata_i;
      end else if (match) begin
         cnt_q <= '0;
      end else if (ctrl_q[0]) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Pending flag, a new match wins over write-one-to-clear
   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stat_q <= 1'b0;
      end else if (match) begin
         stat_q <= 1'b1;
      end else if (wr_stat && hwdata_i[0]) begin
         stat_q <= 1'b0;
      end
   end

   // Interrupt gated by enable
   assign irq_o = stat_q && ctrl_q[1];

endmodule

// ==== ahb_sram_slave.sv ====
////////////////////////////////////////
// Zero-wait SRAM slave with byte lanes
////////////////////////////////////////

`timescale 1ns/1ps

module ahb_sram_slave (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic                   sel_i,
   input  logic                   hwrite_i,
   input  ahb_subsys_pkg::haddr_t haddr_i,
   input  ahb_subsys_pkg::hsize_t hsize_i,
   input  ahb_subsys_pkg::hdata_t hwdata_i,
   output ahb_subsys_pkg::hdata_t hrdata_o
);

   import ahb_subsys_pkg::*;

   // Storage array
   hdata_t     mem [SRAM_DEPTH];

   // Address phase decode
   sram_idx_t  ap_idx;
   logic [3:0] ap_strb;
   logic       fwd_hit;

   // Data phase of the transfer in flight
   logic       dp_wr_q;
   sram_idx_t  dp_idx_q;
   logic [3:0] dp_strb_q;

   // Read path with forwarding lanes
   hdata_t     rd_word_q;
   hdata_t     fwd_data_q;
   logic [3:0] fwd_strb_q;

   // Word index from the byte address
   assign ap_idx = haddr_i[2 +: $bits(sram_idx_t)];

   // Lane strobes from size and low address bits
   always_comb begin
      case (hsize_i)
         HSIZE_BYTE: ap_strb = 4'b0001 << haddr_i[1:0];
         HSIZE_HALF: ap_strb = haddr_i[1] ? 4'b1100 : 4'b0011;
         HSIZE_WORD: ap_strb = 4'b1111;
         // Wider than the bus, no lanes touched
         default:    ap_strb = 4'b0000;
      endcase
   end

   // New address phase hits the word being written right now
   assign fwd_hit = dp_wr_q && (dp_idx_q == ap_idx);

   ////////////////////////////////////////
   // Control state
   ////////////////////////////////////////

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_wr_q    <= 1'b0;
         fwd_strb_q <= 4'b0000;
      end else begin
         dp_wr_q <= sel_i && hwrite_i;
         if (sel_i) begin
            fwd_strb_q <= fwd_hit ? dp_strb_q : 4'b0000;
         end
      end
   end

   // Latched address phase and synchronous read
   always_ff @(posedge hclk_i) begin
      if (sel_i) begin
         dp_idx_q   <= ap_idx;
         dp_strb_q  <= ap_strb;
         rd_word_q  <= mem[ap_idx];
         // Write data of the data phase ending on this edge
         fwd_data_q <= hwdata_i;
      end
   end

   // Lane writes at the end of the data phase
   always_ff @(posedge hclk_i) begin
      if (dp_wr_q) begin
         for (int b = 0; b < 4; b++) begin
            if (dp_strb_q[b]) begin
               mem[dp_idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
            end
         end
      end
   end

   // Forwarded lanes replace the stale array word
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         hrdata_o[8*b +: 8] = fwd_strb_q[b] ? fwd_data_q[8*b +: 8] : rd_word_q[8*b +: 8];
      end
   end

endmodule

// ==== ahb_decoder.sv ====
////////////////////////////////////////
// Address decoder, response mux and
// default ERROR slave
////////////////////////////////////////

`timescale 1ns/1ps

module ahb_decoder (
   input  logic                    hclk_i,
   input  logic                    arst_n_i,
   input  ahb_subsys_pkg::haddr_t  haddr_i,
   input  ahb_subsys_pkg::htrans_t htrans_i,
   input  ahb_subsys_pkg::hdata_t  sram_rdata_i,
   input  ahb_subsys_pkg::hdata_t  timer_rdata_i,
   output logic                    sel_sram_o,
   output logic                    sel_timer_o,
   output ahb_subsys_pkg::hdata_t  hrdata_o,
   output logic                    hready_o,
   output logic                    hresp_o
);

   import ahb_subsys_pkg::*;

   // Address phase qualifiers
   logic       trans_active;
   logic       hit_sram;
   logic       hit_timer;
   logic       accept;
   logic       unmapped;

   // Data phase ownership
   logic       own_sram_q;
   logic       own_timer_q;

   // Response FSM
   dec_state_e state_q;
   dec_state_e state_d;

   ////////////////////////////////////////
   // Address phase
   ////////////////////////////////////////

   // Only NONSEQ and SEQ carry a transfer
   assign trans_active = (htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ);

   // Mask/base match per slave
   assign hit_sram  = (haddr_i & SRAM_MASK) == SRAM_BASE;
   assign hit_timer = (haddr_i & TIMER_MASK) == TIMER_BASE;

   // Transfer taken on this edge
   assign accept = trans_active && hready_o;

   // SRAM wins if the windows ever overlap
   assign sel_sram_o  = accept && hit_sram;
   assign sel_timer_o = accept && hit_timer && !hit_sram;
   assign unmapped    = accept && !hit_sram && !hit_timer;

   ////////////////////////////////////////
   // Response FSM
   ////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         DEC_ERR_FIRST: begin
            // Second ERROR cycle always follows
            state_d = DEC_ERR_SECOND;
         end
         default: begin
            // OKAY and second ERROR cycle both accept a new transfer
            state_d = unmapped ? DEC_ERR_FIRST : DEC_OKAY;
         end
      endcase
   end

   // Bus stalls only in the first ERROR cycle
   assign hready_o = (state_q != DEC_ERR_FIRST);
   assign hresp_o  = (state_q != DEC_OKAY);

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= DEC_OKAY;
         own_sram_q  <= 1'b0;
         own_timer_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // Owner of the next data phase
         if (hready_o) begin
            own_sram_q  <= sel_sram_o;
            own_timer_q <= sel_timer_o;
         end
      end
   end

   // Read data mux, zero for idle and ERROR data phases
   always_comb begin
      hrdata_o = '0;
      if (own_sram_q) begin
         hrdata_o = sram_rdata_i;
      end else if (own_timer_q) begin
         hrdata_o = timer_rdata_i;
      end
   end

endmodule

// ==== ahb_subsys_pkg.sv ====
////////////////////////////////////////
// Bus types, memory map, timer register
// offsets and decoder states
////////////////////////////////////////

package ahb_subsys_pkg;

   ////////////////////////////////////////
   // Bus types
   ////////////////////////////////////////

   // Byte address on the bus
   typedef logic [31:0] haddr_t;

   // Read and write data, one 32-bit word
   typedef logic [31:0] hdata_t;

   // Transfer size code
   typedef logic [2:0] hsize_t;

   // Transfer type code
   typedef logic [1:0] htrans_t;

   // Word index into the SRAM
   typedef logic [8:0] sram_idx_t;

   ////////////////////////////////////////
   // Transfer encodings
   ////////////////////////////////////////

   // BUSY is never issued by the single master
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   localparam hsize_t HSIZE_BYTE = 3'd0;
   localparam hsize_t HSIZE_HALF = 3'd1;
   localparam hsize_t HSIZE_WORD = 3'd2;

   ////////////////////////////////////////
   // Memory map
   ////////////////////////////////////////

   // Number of 32-bit SRAM words
   localparam int SRAM_DEPTH = 512;

   // Slave 0, SRAM in the low 512 MB region
   localparam haddr_t SRAM_BASE = 32'h0000_0000;
   localparam haddr_t SRAM_MASK = 32'hE000_0000;

   // Slave 1, timer in a 64-byte window
   localparam haddr_t TIMER_BASE = 32'h4000_0400;
   localparam haddr_t TIMER_MASK = 32'hFFFF_FFC0;

   // Timer register byte offsets inside its window
   localparam logic [5:0] TIMER_CTRL_OFS = 6'h00;
   localparam logic [5:0] TIMER_CMP_OFS  = 6'h04;
   localparam logic [5:0] TIMER_CNT_OFS  = 6'h08;
   localparam logic [5:0] TIMER_STAT_OFS = 6'h0C;

   ////////////////////////////////////////
   // Decoder response states
   ////////////////////////////////////////

   // Normal OKAY data phase, or one of the two ERROR cycles
   typedef enum logic [1:0] {
      DEC_OKAY,
      DEC_ERR_FIRST,
      DEC_ERR_SECOND
   } dec_state_e;

endpackage
